// File: source/mx_macros.svh
// sizing defines for the merge subsystem, included by the package, the RTL and the testbench
`ifndef MX_MACROS_SVH
`define MX_MACROS_SVH

// symbols carried by one window
// every interface in the subsystem uses this width
`define MX_NUM_SYMBOLS 4

// bits per symbol
// the testbench puts the port id in the top bit
`define MX_SYMBOL_WIDTH 8

// symbols each input stage can buffer
// must be at least MX_NUM_SYMBOLS so a full window fits
`define MX_STAGE_DEPTH 8

// bits needed to count 0 to MX_NUM_SYMBOLS inclusive
`define MX_COUNT_WIDTH $clog2(`MX_NUM_SYMBOLS + 1)

// bits needed for a stage occupancy from 0 to MX_STAGE_DEPTH
`define MX_OCC_WIDTH $clog2(`MX_STAGE_DEPTH + 1)

// a stage always holds at least one full window
// so the offer can be read straight from the bottom slots
`define MX_MIN_DEPTH `MX_NUM_SYMBOLS

`endif

// File: source/mx_pkg.sv
// shared types for the merge subsystem, imported by every RTL module and the testbench
`include "mx_macros.svh"

package mx_pkg;

  // symbol count from 0 up to a full window
  typedef logic [`MX_COUNT_WIDTH-1:0] mx_count_t;

  // one symbol
  typedef logic [`MX_SYMBOL_WIDTH-1:0] mx_symbol_t;

  // window of symbols
  // slot 0 holds the oldest one
  typedef mx_symbol_t [`MX_NUM_SYMBOLS-1:0] mx_window_t;

  // sender side of one interface
  // receivable travels back on its own wire
  typedef struct packed {
    mx_count_t  sendable;
    mx_window_t data;
  } mx_offer_t;

  // port that leads the output window
  typedef enum logic {
    PRI_A = 1'b0,
    PRI_B = 1'b1
  } mx_pri_e;

  // merge composition state
  // held means both ports left symbols behind
  // and the lead contribution is frozen at its leftover
  typedef enum logic {
    MG_OPEN = 1'b0,
    MG_HELD = 1'b1
  } mx_merge_state_e;

endpackage

// File: source/mx_stage.sv
// per-port input buffer that takes a counted push and offers its oldest symbols as a window
`timescale 1ns/1ps
`include "mx_macros.svh"

module mx_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  mx_pkg::mx_offer_t in,
  output mx_pkg::mx_count_t in_receivable,
  input  mx_pkg::mx_count_t pop,
  output mx_pkg::mx_offer_t offer
);

  import mx_pkg::*;

  localparam int depth     = `MX_STAGE_DEPTH;
  localparam int occ_width = `MX_OCC_WIDTH;
  localparam logic [occ_width-1:0] num_occ = occ_width'(`MX_NUM_SYMBOLS);

  // symbol storage
  // slot 0 is the oldest symbol held
  mx_symbol_t [depth-1:0] buf_q;
  mx_symbol_t [depth-1:0] buf_d;

  // number of valid symbols in buf_q
  logic [occ_width-1:0] occ_q;
  logic [occ_width-1:0] occ_d;
  logic [occ_width-1:0] free;
  logic [occ_width-1:0] keep;

  // symbols taken from the producer this cycle
  mx_count_t push;

  // free slots capped at one window
  assign free          = occ_width'(depth) - occ_q;
  assign in_receivable = (free >= num_occ) ? mx_count_t'(num_occ) : mx_count_t'(free);

  // transferred count is the lower of the two sides
  assign push = (in.sendable < in_receivable) ? in.sendable : in_receivable;

  // offer the bottom of the buffer
  // never more than a window
  assign offer.sendable = (occ_q >= num_occ) ? mx_count_t'(num_occ) : mx_count_t'(occ_q);
  assign offer.data     = mx_window_t'(buf_q[`MX_NUM_SYMBOLS-1:0]);

  // symbols that survive the pop
  assign keep  = occ_q - occ_width'(pop);
  assign occ_d = keep + occ_width'(push);

  // shift out the popped symbols and append the pushed ones on top
  always_comb begin
    int src;
    int slot;
    for (int i = 0; i < depth; i++) begin
      src  = i + int'(pop);
      slot = i - int'(keep);
      if (i < int'(keep) && src < depth) begin
        buf_d[i] = buf_q[src];
      end else if (slot >= 0 && slot < int'(push) && slot < `MX_NUM_SYMBOLS) begin
        buf_d[i] = in.data[slot];
      end else begin
        // slot above occupancy keeps stale data
        buf_d[i] = buf_q[i];
      end
    end
  end

  // occupancy is control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  // the merge must only take what this stage offers
  pop_within_offer_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop <= offer.sendable
  ) else $error("mx_stage pop %0d exceeds offer %0d", pop, offer.sendable);

  // occupancy must stay inside the buffer
  occ_bound_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    occ_q <= occ_width'(depth)
  ) else $error("mx_stage occupancy %0d out of range", occ_q);

  // the buffer has to hold at least one window
  initial begin
    if (depth < `MX_MIN_DEPTH) begin
      $error("mx_stage depth %0d below window size", depth);
    end
  end

endmodule

// File: source/mx_merge.sv
// merge of two stage windows into one output window with leftover order kept and rotating priority
`timescale 1ns/1ps
`include "mx_macros.svh"

module mx_merge (
  input  logic              clk,
  input  logic              rst_n,
  input  mx_pkg::mx_offer_t a,
  input  mx_pkg::mx_offer_t b,
  output mx_pkg::mx_count_t pop_a,
  output mx_pkg::mx_count_t pop_b,
  output mx_pkg::mx_offer_t out,
  input  mx_pkg::mx_count_t out_receivable
);

  import mx_pkg::*;

  localparam mx_count_t num_sym = mx_count_t'(`MX_NUM_SYMBOLS);

  // priority and hold state
  mx_pri_e         pri_q;
  mx_pri_e         pri_d;
  mx_merge_state_e state_q;
  mx_merge_state_e state_d;
  // leftover count of the lead port while held
  mx_count_t       cap_q;
  mx_count_t       cap_d;

  mx_offer_t lead;
  mx_offer_t other;
  mx_count_t lead_cnt;
  mx_count_t other_cnt;
  mx_count_t xfer;
  mx_count_t pop_lead;
  mx_count_t pop_other;
  mx_count_t left_lead;
  mx_count_t left_other;
  logic      both_offered;

  // route the ports by priority
  assign lead  = (pri_q == PRI_A) ? a : b;
  assign other = (pri_q == PRI_A) ? b : a;

  // held lead contribution is frozen at its leftover
  assign lead_cnt  = (state_q == MG_HELD && cap_q < lead.sendable) ? cap_q : lead.sendable;
  // other port fills what is left of the window
  assign other_cnt = (other.sendable < num_sym - lead_cnt) ? other.sendable : num_sym - lead_cnt;

  assign out.sendable = lead_cnt + other_cnt;

  // lead symbols first then the other port's oldest
  always_comb begin
    int j;
    for (int i = 0; i < `MX_NUM_SYMBOLS; i++) begin
      j = i - int'(lead_cnt);
      if (j < 0) begin
        out.data[i] = lead.data[i];
      end else begin
        out.data[i] = other.data[j];
      end
    end
  end

  // transfer is taken from the bottom so the lead drains first
  assign xfer       = (out.sendable < out_receivable) ? out.sendable : out_receivable;
  assign pop_lead   = (xfer < lead_cnt) ? xfer : lead_cnt;
  assign pop_other  = xfer - pop_lead;
  assign left_lead  = lead_cnt - pop_lead;
  assign left_other = other_cnt - pop_other;

  assign pop_a = (pri_q == PRI_A) ? pop_lead : pop_other;
  assign pop_b = (pri_q == PRI_A) ? pop_other : pop_lead;

  assign both_offered = (a.sendable != '0) && (b.sendable != '0);

  // next composition from what is left behind
  always_comb begin
    state_d = MG_OPEN;
    cap_d   = '0;
    pri_d   = pri_q;
    if (left_lead != '0 && left_other != '0) begin
      // both left symbols so freeze the lead part
      state_d = MG_HELD;
      cap_d   = left_lead;
    end else if (left_other != '0) begin
      // only the other port is behind so it leads
      pri_d = (pri_q == PRI_A) ? PRI_B : PRI_A;
    end else if (left_lead == '0 && both_offered) begin
      // window fully taken so rotate for fairness
      pri_d = (pri_q == PRI_A) ? PRI_B : PRI_A;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pri_q   <= PRI_A;
      state_q <= MG_OPEN;
      cap_q   <= '0;
    end else begin
      pri_q   <= pri_d;
      state_q <= state_d;
      cap_q   <= cap_d;
    end
  end

  // pops on both ports add up to the output transfer
  pop_split_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    int'(pop_a) + int'(pop_b) == int'(xfer)
  ) else $error("mx_merge pops %0d + %0d differ from transfer %0d", pop_a, pop_b, xfer);

  // a held lead still offers at least its leftover
  held_cap_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == MG_HELD) |-> (cap_q != '0 && lead.sendable >= cap_q)
  ) else $error("mx_merge held with cap %0d lead %0d", cap_q, lead.sendable);

endmodule

// File: source/mx_sendable_checks.sv
// integrity checker without outputs, placed on one multi-transfer interface to watch its sender
`timescale 1ns/1ps

module mx_sendable_checks #(
  parameter int num_symbols  = 2,
  parameter int symbol_width = 1,
  localparam int count_width = $clog2(num_symbols + 1)
) (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic [count_width-1:0]                   receivable,
  input logic [count_width-1:0]                   sendable,
  input logic [num_symbols-1:0][symbol_width-1:0] data
);

  logic [count_width-1:0] xfer;
  logic [count_width-1:0] hold;
  // held count from the previous cycle
  logic [count_width-1:0] hold_q;

  // leftover moved down to slot 0
  logic [num_symbols-1:0][symbol_width-1:0] shifted;
  logic [num_symbols-1:0][symbol_width-1:0] shifted_q;
  // current data with slots above the leftover cleared
  logic [num_symbols-1:0][symbol_width-1:0] masked;

  assign xfer = (sendable < receivable) ? sendable : receivable;
  assign hold = (sendable > receivable) ? sendable - receivable : '0;

  always_comb begin
    int src;
    for (int i = 0; i < num_symbols; i++) begin
      src = i + int'(xfer);
      shifted[i] = '0;
      masked[i]  = '0;
      if (i < int'(hold) && src < num_symbols) begin
        shifted[i] = data[src];
      end
      if (i < int'(hold_q)) begin
        masked[i] = data[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_q <= '0;
    end else begin
      hold_q <= hold;
    end
  end

  // leftover window as it stood last cycle
  always_ff @(posedge clk) begin
    shifted_q <= shifted;
  end

  // leftover symbols stay offered
  no_revocation_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (hold_q != '0) |-> (sendable >= hold_q)
  ) else $error("sendable %0d dropped below leftover %0d", sendable, hold_q);

  // leftover symbols reappear unchanged at the bottom
  data_stable_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (hold_q != '0) |-> (masked == shifted_q)
  ) else $error("leftover data changed while held");

  // offered slots never carry unknown bits
  for (genvar i = 0; i < num_symbols; i++) begin : gen_known
    data_known_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      (sendable > i) |-> !$isunknown(data[i])
    ) else $error("offered slot %0d is unknown", i);
  end

endmodule

// File: source/mx_merge_top.sv
// top of the merge subsystem with two input stages, the merge block and interface checkers
`timescale 1ns/1ps
`include "mx_macros.svh"

module mx_merge_top (
  input  logic              clk,
  input  logic              rst_n,
  input  mx_pkg::mx_offer_t in_a,
  input  mx_pkg::mx_offer_t in_b,
  output mx_pkg::mx_count_t in_a_receivable,
  output mx_pkg::mx_count_t in_b_receivable,
  output mx_pkg::mx_offer_t out,
  input  mx_pkg::mx_count_t out_receivable
);

  import mx_pkg::*;

  // stage windows toward the merge
  mx_offer_t offer_a;
  mx_offer_t offer_b;
  // symbols the merge takes from each stage
  mx_count_t pop_a;
  mx_count_t pop_b;

  // port a buffer
  mx_stage stage_a_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in            (in_a),
    .in_receivable (in_a_receivable),
    .pop           (pop_a),
    .offer         (offer_a)
  );

  // port b buffer
  mx_stage stage_b_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in            (in_b),
    .in_receivable (in_b_receivable),
    .pop           (pop_b),
    .offer         (offer_b)
  );

  mx_merge merge_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .a              (offer_a),
    .b              (offer_b),
    .pop_a          (pop_a),
    .pop_b          (pop_b),
    .out            (out),
    .out_receivable (out_receivable)
  );

  // producer a toward stage a
  mx_sendable_checks #(
    .num_symbols  (`MX_NUM_SYMBOLS),
    .symbol_width (`MX_SYMBOL_WIDTH)
  ) chk_a_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .receivable (in_a_receivable),
    .sendable   (in_a.sendable),
    .data       (in_a.data)
  );

  // producer b toward stage b
  mx_sendable_checks #(
    .num_symbols  (`MX_NUM_SYMBOLS),
    .symbol_width (`MX_SYMBOL_WIDTH)
  ) chk_b_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .receivable (in_b_receivable),
    .sendable   (in_b.sendable),
    .data       (in_b.data)
  );

  // merged output toward the downstream
  mx_sendable_checks #(
    .num_symbols  (`MX_NUM_SYMBOLS),
    .symbol_width (`MX_SYMBOL_WIDTH)
  ) chk_out_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .receivable (out_receivable),
    .sendable   (out.sendable),
    .data       (out.data)
  );

endmodule

// File: tests/mx_merge_tb_checks.sv
// scoreboard and concurrent assertions on the merge subsystem ports, instantiated by the testbench
`timescale 1ns/1ps
`include "mx_macros.svh"

module mx_merge_tb_checks (
  input  logic              clk,
  input  logic              rst_n,
  input  mx_pkg::mx_offer_t in_a,
  input  mx_pkg::mx_offer_t in_b,
  input  mx_pkg::mx_count_t in_a_receivable,
  input  mx_pkg::mx_count_t in_b_receivable,
  input  mx_pkg::mx_offer_t out,
  input  mx_pkg::mx_count_t out_receivable,
  input  logic              fair_phase,
  input  logic              end_check,
  output logic              idle,
  output int                error_count
);

  import mx_pkg::*;

  localparam int n  = `MX_NUM_SYMBOLS;
  localparam int sw = `MX_SYMBOL_WIDTH;

  int errors = 0;
  // symbols pushed into and seen leaving each port
  int tx_a;
  int tx_b;
  int rx_a;
  int rx_b;
  int occ_a;
  int occ_b;
  // next sequence number due at the output per port
  logic [sw-2:0] next_a;
  logic [sw-2:0] next_b;
  int got_a;
  int got_b;
  logic order_ok;
  // output leftover of the last cycle, moved down to slot 0
  int left_now;
  int left_q;
  mx_window_t shift_win;
  mx_window_t shift_q;
  logic left_match;
  // fairness history
  logic fair_now;
  logic prev_fair;
  logic prev_port;

  function automatic int min_int(int x, int y);
    return (x < y) ? x : y;
  endfunction

  // what a stage may accept for a given occupancy
  function automatic int expected_receivable(int occ);
    return min_int(n, `MX_STAGE_DEPTH - occ);
  endfunction

  task automatic note_failure(string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errors = errors + 1;
  endtask

  always_comb begin
    int xfer;
    int src;
    logic [sw-2:0] want;
    xfer     = min_int(int'(out.sendable), int'(out_receivable));
    left_now = int'(out.sendable) - xfer;
    got_a      = 0;
    got_b      = 0;
    order_ok   = 1'b1;
    left_match = 1'b1;
    for (int i = 0; i < n; i++) begin
      // transferred slots must continue each port's sequence
      if (i < xfer) begin
        if (out.data[i][sw-1]) begin
          want = next_b + got_b[sw-2:0];
          got_b++;
        end else begin
          want = next_a + got_a[sw-2:0];
          got_a++;
        end
        if (out.data[i][sw-2:0] != want) begin
          order_ok = 1'b0;
        end
      end
      src = i + xfer;
      shift_win[i] = (i < left_now && src < n) ? out.data[src] : '0;
      if (i < left_q && out.data[i] != shift_q[i]) begin
        left_match = 1'b0;
      end
    end
  end

  assign occ_a       = tx_a - rx_a;
  assign occ_b       = tx_b - rx_b;
  assign fair_now    = fair_phase && occ_a > 0 && occ_b > 0 && int'(out_receivable) == n;
  // DUT offers nothing and no producer has anything on offer
  assign idle        = out.sendable == '0 && in_a.sendable == '0 && in_b.sendable == '0;
  assign error_count = errors;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_a      <= 0;
      tx_b      <= 0;
      rx_a      <= 0;
      rx_b      <= 0;
      next_a    <= '0;
      next_b    <= '0;
      left_q    <= 0;
      shift_q   <= '0;
      prev_fair <= 1'b0;
      prev_port <= 1'b0;
    end else begin
      tx_a      <= tx_a + min_int(int'(in_a.sendable), int'(in_a_receivable));
      tx_b      <= tx_b + min_int(int'(in_b.sendable), int'(in_b_receivable));
      rx_a      <= rx_a + got_a;
      rx_b      <= rx_b + got_b;
      next_a    <= next_a + got_a[sw-2:0];
      next_b    <= next_b + got_b[sw-2:0];
      left_q    <= left_now;
      shift_q   <= shift_win;
      prev_fair <= fair_now;
      prev_port <= out.data[0][sw-1];
    end
  end

  order_a : assert property (@(posedge clk) disable iff (!rst_n) order_ok)
    else note_failure("output sequence numbers not consecutive");
  rcv_a_a : assert property (@(posedge clk) disable iff (!rst_n)
    int'(in_a_receivable) == expected_receivable(occ_a))
    else note_failure($sformatf("in_a_receivable %0d, occupancy %0d", in_a_receivable, occ_a));
  rcv_b_a : assert property (@(posedge clk) disable iff (!rst_n)
    int'(in_b_receivable) == expected_receivable(occ_b))
    else note_failure($sformatf("in_b_receivable %0d, occupancy %0d", in_b_receivable, occ_b));
  // leftover stays offered and slides down unchanged
  integrity_a : assert property (@(posedge clk) disable iff (!rst_n)
    (left_q > 0) |-> (int'(out.sendable) >= left_q && left_match))
    else note_failure($sformatf("output leftover %0d not kept, sendable %0d", left_q, out.sendable));
  // with no leftover pending the window fills up to the total occupancy
  // a held composition may offer less than that
  bound_a : assert property (@(posedge clk) disable iff (!rst_n)
    int'(out.sendable) <= min_int(n, occ_a + occ_b) &&
    (occ_a + occ_b == 0 || out.sendable != '0) &&
    (left_q > 0 || int'(out.sendable) == min_int(n, occ_a + occ_b)))
    else note_failure($sformatf("out.sendable %0d, total occupancy %0d", out.sendable, occ_a + occ_b));
  fair_a : assert property (@(posedge clk) disable iff (!rst_n)
    (prev_fair && fair_now) |-> (out.data[0][sw-1] != prev_port))
    else note_failure("slot 0 port did not alternate");
  reset_a : assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
    (out.sendable == '0 && int'(in_a_receivable) == n && int'(in_b_receivable) == n))
    else note_failure("outputs not in reset state");
  complete_a : assert property (@(posedge clk) disable iff (!rst_n)
    end_check |-> (rx_a == tx_a && rx_b == tx_b))
    else note_failure($sformatf("received %0d/%0d of pushed %0d/%0d", rx_a, rx_b, tx_a, tx_b));

endmodule

// File: tests/mx_merge_top_tb.sv
// testbench for the merge subsystem with clock, reset, seeded producers and downstream, and the verdict
`timescale 1ns/1ps
`include "mx_macros.svh"

module mx_merge_top_tb;

  import mx_pkg::*;

  localparam int n           = `MX_NUM_SYMBOLS;
  localparam int drain_limit = 300;

  logic      clk;
  logic      rst_n;
  mx_offer_t in_a;
  mx_offer_t in_b;
  mx_count_t in_a_receivable;
  mx_count_t in_b_receivable;
  mx_offer_t out;
  mx_count_t out_receivable;
  logic      fair_phase;
  logic      end_check;
  logic      idle;
  int        error_count;
  int        seed;
  int        timeouts;
  // oldest unsent sequence number per producer
  logic [`MX_SYMBOL_WIDTH-2:0] seq_a;
  logic [`MX_SYMBOL_WIDTH-2:0] seq_b;
  // 0 random, 1 full, 2 stall, 3 drain
  int mode;

  mx_merge_top dut_i (.*);

  mx_merge_tb_checks checks_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // next n symbols of a port, oldest in slot 0
  function automatic mx_window_t build_window(logic port, logic [`MX_SYMBOL_WIDTH-2:0] first);
    mx_window_t w;
    for (int i = 0; i < n; i++) begin
      w[i] = {port, first + (`MX_SYMBOL_WIDTH-1)'(i)};
    end
    return w;
  endfunction

  // producer count, never below what it left behind
  task automatic next_offer(input int hold, output int cnt);
    int r;
    r = int'($unsigned($random(seed)) % (n + 1));
    case (mode)
      1: cnt = n;
      3: cnt = hold;
      default: cnt = (r > hold) ? r : hold;
    endcase
  endtask

  // sample transfers mid cycle, drive the next offers after the edge
  task automatic step();
    int xfer_a;
    int xfer_b;
    int cnt;
    int r;
    @(negedge clk);
    xfer_a = (in_a.sendable < in_a_receivable) ? int'(in_a.sendable) : int'(in_a_receivable);
    xfer_b = (in_b.sendable < in_b_receivable) ? int'(in_b.sendable) : int'(in_b_receivable);
    @(posedge clk);
    #1;
    seq_a = seq_a + xfer_a[`MX_SYMBOL_WIDTH-2:0];
    next_offer(int'(in_a.sendable) - xfer_a, cnt);
    in_a.sendable = mx_count_t'(cnt);
    in_a.data     = build_window(1'b0, seq_a);
    seq_b = seq_b + xfer_b[`MX_SYMBOL_WIDTH-2:0];
    next_offer(int'(in_b.sendable) - xfer_b, cnt);
    in_b.sendable = mx_count_t'(cnt);
    in_b.data     = build_window(1'b1, seq_b);
    r = int'($unsigned($random(seed)) % (n + 1));
    case (mode)
      1, 3: out_receivable = mx_count_t'(n);
      2: out_receivable = '0;
      default: out_receivable = mx_count_t'(r);
    endcase
    fair_phase = (mode == 1);
  endtask

  task automatic run_cycles(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      step();
    end
  endtask

  // producers only finish what they offered, downstream takes everything
  task automatic wait_drain();
    int k;
    k = 0;
    while (!idle && k < drain_limit) begin
      step();
      k++;
    end
    if (!idle) begin
      $display("drain timed out after %0d cycles with symbols still buffered", drain_limit);
      timeouts++;
    end
  endtask

  initial begin
    seed           = 32'h24ab5bdd;
    timeouts       = 0;
    mode           = 0;
    rst_n          = 1'b0;
    in_a           = '0;
    in_b           = '0;
    out_receivable = '0;
    fair_phase     = 1'b0;
    end_check      = 1'b0;
    seq_a          = '0;
    seq_b          = '0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    run_cycles(300);
    mode = 1;
    run_cycles(60);
    mode = 2;
    run_cycles(40);
    mode = 3;
    wait_drain();
    // one sampled cycle for the completeness check
    end_check = 1'b1;
    step();
    end_check = 1'b0;
    step();
    $display("errors: assertion failures %0d, timeouts %0d", error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
source/mx_pkg.sv
source/mx_stage.sv
source/mx_merge.sv
source/mx_sendable_checks.sv
source/mx_merge_top.sv
tests/mx_merge_tb_checks.sv
tests/mx_merge_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mx_merge_top_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
